//--- logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int unsigned XLEN    = 32;
    localparam int unsigned REG_AW  = 5;
    localparam int unsigned OP3R_W  = 17;  // inst[31:15]
    localparam int unsigned OP2RI_W = 10;  // inst[31:22]

    // 3R opcodes, LoongArch base encoding
    localparam logic [OP3R_W-1:0] OP_ADD_W = 17'h00020;
    localparam logic [OP3R_W-1:0] OP_SUB_W = 17'h00022;
    localparam logic [OP3R_W-1:0] OP_SLT   = 17'h00024;
    localparam logic [OP3R_W-1:0] OP_AND   = 17'h00029;
    localparam logic [OP3R_W-1:0] OP_OR    = 17'h0002a;
    localparam logic [OP3R_W-1:0] OP_XOR   = 17'h0002b;

    // 2RI12 opcodes
    localparam logic [OP2RI_W-1:0] OP_ADDI_W = 10'h00a;
    localparam logic [OP2RI_W-1:0] OP_LD_W   = 10'h0a2;
    localparam logic [OP2RI_W-1:0] OP_ST_W   = 10'h0a6;

    localparam int unsigned ALU_OP_W = 3;

    localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLT = 3'd5;

    // operand source in EX
    localparam int unsigned FWD_W = 2;

    localparam logic [FWD_W-1:0] FWD_RF  = 2'b00;
    localparam logic [FWD_W-1:0] FWD_MEM = 2'b10;
    localparam logic [FWD_W-1:0] FWD_WB  = 2'b01;

    typedef struct packed {
        logic [OP3R_W-1:0] opcode;
        logic [REG_AW-1:0] rk;
        logic [REG_AW-1:0] rj;
        logic [REG_AW-1:0] rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [OP2RI_W-1:0] opcode;
        logic [11:0]        si12;
        logic [REG_AW-1:0]  rj;
        logic [REG_AW-1:0]  rd;
    } fmt_2ri12_t;

    // same 32 bits, read both ways by the decoder
    typedef union packed {
        fmt_3r_t    r3;
        fmt_2ri12_t ri12;
    } instr_word_t;

endpackage

`default_nettype wire

//--- logic/reg_file.sv
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  wire               clk,
    input  wire               reset,
    input  wire  [REG_AW-1:0] rd_addr_a,
    input  wire  [REG_AW-1:0] rd_addr_b,
    input  wire               wr_en,
    input  wire  [REG_AW-1:0] wr_addr,
    input  wire  [XLEN-1:0]   wr_data,
    output logic [XLEN-1:0]   rd_data_a,
    output logic [XLEN-1:0]   rd_data_b
);

    logic [XLEN-1:0] regs [32];
    logic            wr_live;

    assign wr_live = wr_en && (wr_addr != '0);  // r0 stays zero

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr_live)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-through so ID sees the WB value of this cycle
    assign rd_data_a = (wr_live && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (wr_live && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 instr_valid,
    input  instr_word_t         instr,
    input  wire                 instr_ready,
    input  wire  [XLEN-1:0]     rd_data_a,
    input  wire  [XLEN-1:0]     rd_data_b,
    output logic [REG_AW-1:0]   rd_addr_a,
    output logic [REG_AW-1:0]   rd_addr_b,
    output logic                id_use_a,
    output logic                id_use_b,
    output logic                ex_valid,
    output logic [ALU_OP_W-1:0] ex_alu_op,
    output logic                ex_use_imm,
    output logic [XLEN-1:0]     ex_imm,
    output logic [REG_AW-1:0]   ex_src_a,
    output logic [REG_AW-1:0]   ex_src_b,
    output logic [XLEN-1:0]     ex_op_a,
    output logic [XLEN-1:0]     ex_op_b,
    output logic                ex_is_load,
    output logic                ex_is_store,
    output logic                ex_we,
    output logic [REG_AW-1:0]   ex_rd
);

    logic                is_3r;
    logic                is_ri;  // any 2RI12 op
    logic                is_load;
    logic                is_store;
    logic [ALU_OP_W-1:0] alu_op;
    logic                dec_we;
    logic                accept;

    always_comb
    begin
        is_3r    = 1'b1;
        is_ri    = 1'b1;
        is_load  = 1'b0;
        is_store = 1'b0;
        alu_op   = ALU_ADD;   // also the address add for ld/st
        case (instr.r3.opcode)
            OP_ADD_W: alu_op = ALU_ADD;
            OP_SUB_W: alu_op = ALU_SUB;
            OP_AND:   alu_op = ALU_AND;
            OP_OR:    alu_op = ALU_OR;
            OP_XOR:   alu_op = ALU_XOR;
            OP_SLT:   alu_op = ALU_SLT;
            default:  is_3r = 1'b0;
        endcase
        case (instr.ri12.opcode)
            OP_ADDI_W: is_load = 1'b0;
            OP_LD_W:   is_load = 1'b1;
            OP_ST_W:   is_store = 1'b1;
            default:   is_ri = 1'b0;
        endcase
    end

    // undefined opcodes fall through with no sources and no write
    assign rd_addr_a = instr.r3.rj;
    assign rd_addr_b = is_store ? instr.ri12.rd : instr.r3.rk;
    assign id_use_a  = is_3r | is_ri;
    assign id_use_b  = is_3r | is_store;
    assign dec_we    = (is_3r | (is_ri & ~is_store)) & (instr.r3.rd != '0);
    assign accept    = instr_valid & instr_ready;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            ex_valid    <= 1'b0;
            ex_is_load  <= 1'b0;
            ex_is_store <= 1'b0;
            ex_we       <= 1'b0;
            ex_rd       <= '0;
            ex_src_a    <= '0;
            ex_src_b    <= '0;
        end
        else
        begin
            ex_valid    <= accept;  // bubble when nothing taken
            ex_is_load  <= accept & is_load;
            ex_is_store <= accept & is_store;
            ex_we       <= accept & dec_we;
            ex_rd       <= accept ? instr.r3.rd : '0;
            ex_src_a    <= (accept & id_use_a) ? rd_addr_a : '0;  // r0 never forwarded
            ex_src_b    <= (accept & id_use_b) ? rd_addr_b : '0;
        end
    end

    always_ff @(posedge clk)
    begin
        ex_alu_op  <= alu_op;
        ex_use_imm <= is_ri;
        ex_imm     <= {{(XLEN-12){instr.ri12.si12[11]}}, instr.ri12.si12};
        ex_op_a    <= rd_data_a;
        ex_op_b    <= rd_data_b;
    end

endmodule

`default_nettype wire

//--- logic/hazard_forward.sv
`default_nettype none

module hazard_forward import cpu_pkg::*; (
    input  wire               instr_valid,
    input  wire  [REG_AW-1:0] rd_addr_a,
    input  wire  [REG_AW-1:0] rd_addr_b,
    input  wire               id_use_a,
    input  wire               id_use_b,
    input  wire               ex_valid,
    input  wire               ex_is_load,
    input  wire  [REG_AW-1:0] ex_rd,
    input  wire  [REG_AW-1:0] ex_src_a,
    input  wire  [REG_AW-1:0] ex_src_b,
    input  wire               mem_we,
    input  wire  [REG_AW-1:0] mem_rd,
    input  wire               wb_we,
    input  wire  [REG_AW-1:0] wb_rd,
    output logic              instr_ready,
    output logic [FWD_W-1:0]  fwd_a,
    output logic [FWD_W-1:0]  fwd_b
);

    logic load_in_ex;
    logic stall;

    // newest producer wins, r0 is never forwarded
    function automatic logic [FWD_W-1:0] fwd_sel(input logic [REG_AW-1:0] src,
                                                 input logic              m_we,
                                                 input logic [REG_AW-1:0] m_rd,
                                                 input logic              w_we,
                                                 input logic [REG_AW-1:0] w_rd);
        if (src == '0)
            return FWD_RF;
        else if (m_we && m_rd == src)
            return FWD_MEM;
        else if (w_we && w_rd == src)
            return FWD_WB;
        else
            return FWD_RF;
    endfunction

    assign load_in_ex = ex_valid && ex_is_load && (ex_rd != '0);

    assign stall = instr_valid && load_in_ex &&
                   ((id_use_a && rd_addr_a == ex_rd) || (id_use_b && rd_addr_b == ex_rd));

    assign instr_ready = ~stall;  // bubble goes into EX next edge

    assign fwd_a = fwd_sel(ex_src_a, mem_we, mem_rd, wb_we, wb_rd);
    assign fwd_b = fwd_sel(ex_src_b, mem_we, mem_rd, wb_we, wb_rd);

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 ex_valid,
    input  wire  [ALU_OP_W-1:0] ex_alu_op,
    input  wire                 ex_use_imm,
    input  wire  [XLEN-1:0]     ex_imm,
    input  wire  [XLEN-1:0]     ex_op_a,
    input  wire  [XLEN-1:0]     ex_op_b,
    input  wire                 ex_is_load,
    input  wire                 ex_is_store,
    input  wire                 ex_we,
    input  wire  [REG_AW-1:0]   ex_rd,
    input  wire  [FWD_W-1:0]    fwd_a,
    input  wire  [FWD_W-1:0]    fwd_b,
    input  wire  [XLEN-1:0]     wb_data,
    output logic                mem_valid,
    output logic                mem_is_load,
    output logic                mem_is_store,
    output logic                mem_we,
    output logic [REG_AW-1:0]   mem_rd,
    output logic [XLEN-1:0]     mem_result,     // also the EX/MEM forward source
    output logic [XLEN-1:0]     mem_store_data
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;  // forwarded rk, or rd for a store
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_out;

    function automatic logic [XLEN-1:0] fwd_mux(input logic [FWD_W-1:0] sel,
                                                input logic [XLEN-1:0]  rf_val,
                                                input logic [XLEN-1:0]  mem_val,
                                                input logic [XLEN-1:0]  wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    assign op_a  = fwd_mux(fwd_a, ex_op_a, mem_result, wb_data);
    assign op_b  = fwd_mux(fwd_b, ex_op_b, mem_result, wb_data);
    assign alu_b = ex_use_imm ? ex_imm : op_b;

    always_comb
    begin
        case (ex_alu_op)
            ALU_ADD: alu_out = op_a + alu_b;
            ALU_SUB: alu_out = op_a - alu_b;
            ALU_AND: alu_out = op_a & alu_b;
            ALU_OR:  alu_out = op_a | alu_b;
            ALU_XOR: alu_out = op_a ^ alu_b;
            ALU_SLT: alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            mem_valid    <= 1'b0;
            mem_is_load  <= 1'b0;
            mem_is_store <= 1'b0;
            mem_we       <= 1'b0;
            mem_rd       <= '0;
        end
        else
        begin
            mem_valid    <= ex_valid;
            mem_is_load  <= ex_is_load;
            mem_is_store <= ex_is_store;
            mem_we       <= ex_we;
            mem_rd       <= ex_rd;
        end
    end

    always_ff @(posedge clk)
    begin
        mem_result     <= alu_out;
        mem_store_data <= op_b;
    end

endmodule

`default_nettype wire

//--- logic/mem_stage.sv
`default_nettype none

module mem_stage import cpu_pkg::*; #(
    parameter int unsigned DATA_DEPTH = 64
) (
    input  wire               clk,
    input  wire               reset,
    input  wire               mem_valid,
    input  wire               mem_is_load,
    input  wire               mem_is_store,
    input  wire               mem_we,
    input  wire  [REG_AW-1:0] mem_rd,
    input  wire  [XLEN-1:0]   mem_result,
    input  wire  [XLEN-1:0]   mem_store_data,
    output logic              wb_valid,
    output logic              wb_we,
    output logic [REG_AW-1:0] wb_rd,
    output logic [XLEN-1:0]   wb_data
);

    localparam int unsigned IDX_W = $clog2(DATA_DEPTH);

    logic [XLEN-1:0]  ram [DATA_DEPTH];
    logic [IDX_W-1:0] word_idx;

    // bits 1:0 dropped, upper bits wrap
    assign word_idx = mem_result[IDX_W+1:2];

    always_ff @(posedge clk)
    begin
        if (mem_valid && mem_is_store)
            ram[word_idx] <= mem_store_data;
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            wb_valid <= 1'b0;
            wb_we    <= 1'b0;
            wb_rd    <= '0;
        end
        else
        begin
            wb_valid <= mem_valid;
            wb_we    <= mem_we;
            wb_rd    <= mem_rd;
        end
    end

    // store address rides along for st.w
    always_ff @(posedge clk)
    begin
        wb_data <= mem_is_load ? ram[word_idx] : mem_result;
    end

endmodule

`default_nettype wire

//--- logic/cpu_top.sv
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter int unsigned DATA_DEPTH = 64
) (
    input  wire              clk,
    input  wire              reset,
    input  wire              instr_valid,
    input  instr_word_t      instr,
    output logic             instr_ready,
    output logic             wb_valid,
    output logic             wb_we,
    output logic [REG_AW-1:0] wb_rd,
    output logic [XLEN-1:0]  wb_data
);

    // ID side
    logic [REG_AW-1:0]   rd_addr_a;
    logic [REG_AW-1:0]   rd_addr_b;
    logic [XLEN-1:0]     rd_data_a;
    logic [XLEN-1:0]     rd_data_b;
    logic                id_use_a;
    logic                id_use_b;

    // ID/EX
    logic                ex_valid;
    logic [ALU_OP_W-1:0] ex_alu_op;
    logic                ex_use_imm;
    logic [XLEN-1:0]     ex_imm;
    logic [REG_AW-1:0]   ex_src_a;
    logic [REG_AW-1:0]   ex_src_b;
    logic [XLEN-1:0]     ex_op_a;
    logic [XLEN-1:0]     ex_op_b;
    logic                ex_is_load;
    logic                ex_is_store;
    logic                ex_we;
    logic [REG_AW-1:0]   ex_rd;

    logic [FWD_W-1:0]    fwd_a;
    logic [FWD_W-1:0]    fwd_b;

    // EX/MEM
    logic                mem_valid;
    logic                mem_is_load;
    logic                mem_is_store;
    logic                mem_we;
    logic [REG_AW-1:0]   mem_rd;
    logic [XLEN-1:0]     mem_result;
    logic [XLEN-1:0]     mem_store_data;

    decode_stage u_decode (
        .clk(clk), .reset(reset),
        .instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .id_use_a(id_use_a), .id_use_b(id_use_b),
        .ex_valid(ex_valid), .ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm), .ex_imm(ex_imm),
        .ex_src_a(ex_src_a), .ex_src_b(ex_src_b), .ex_op_a(ex_op_a), .ex_op_b(ex_op_b),
        .ex_is_load(ex_is_load), .ex_is_store(ex_is_store), .ex_we(ex_we), .ex_rd(ex_rd)
    );

    reg_file u_reg_file (
        .clk(clk), .reset(reset),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .wr_en(wb_we), .wr_addr(wb_rd), .wr_data(wb_data),  // WB writes back
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b)
    );

    hazard_forward u_hazard_forward (
        .instr_valid(instr_valid),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b), .id_use_a(id_use_a), .id_use_b(id_use_b),
        .ex_valid(ex_valid), .ex_is_load(ex_is_load), .ex_rd(ex_rd),
        .ex_src_a(ex_src_a), .ex_src_b(ex_src_b),
        .mem_we(mem_we), .mem_rd(mem_rd), .wb_we(wb_we), .wb_rd(wb_rd),
        .instr_ready(instr_ready), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    execute_stage u_execute (
        .clk(clk), .reset(reset),
        .ex_valid(ex_valid), .ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm), .ex_imm(ex_imm),
        .ex_op_a(ex_op_a), .ex_op_b(ex_op_b), .ex_is_load(ex_is_load),
        .ex_is_store(ex_is_store), .ex_we(ex_we), .ex_rd(ex_rd),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .wb_data(wb_data),
        .mem_valid(mem_valid), .mem_is_load(mem_is_load), .mem_is_store(mem_is_store),
        .mem_we(mem_we), .mem_rd(mem_rd), .mem_result(mem_result),
        .mem_store_data(mem_store_data)
    );

    mem_stage #(.DATA_DEPTH(DATA_DEPTH)) u_mem (
        .clk(clk), .reset(reset),
        .mem_valid(mem_valid), .mem_is_load(mem_is_load), .mem_is_store(mem_is_store),
        .mem_we(mem_we), .mem_rd(mem_rd), .mem_result(mem_result),
        .mem_store_data(mem_store_data),
        .wb_valid(wb_valid), .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data)
    );

endmodule

`default_nettype wire

//--- bench/cpu_assert.sv
`default_nettype none

module cpu_assert (
    input wire clk,
    input wire reset,
    input wire instr_ready,
    input wire wb_valid,
    input wire wb_we
);

    // a register write only comes with a retiring instruction
    we_implies_valid: assert property (@(posedge clk) disable iff (!reset) wb_we |-> wb_valid)
        else $error("wb_we high while wb_valid is low");

    single_stall: assert property (@(posedge clk) disable iff (!reset)
                                   !instr_ready |=> instr_ready)
        else $error("instr_ready low two cycles in a row");  // load-use is one bubble

    quiet_after_reset: assert property (@(posedge clk) $rose(reset) |-> !wb_valid)
        else $error("wb_valid high in the first cycle after reset");

endmodule

bind cpu_top cpu_assert u_assert (
    .clk(clk),
    .reset(reset),
    .instr_ready(instr_ready),
    .wb_valid(wb_valid),
    .wb_we(wb_we)
);

`default_nettype wire

//--- bench/cpu_tb.sv
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    localparam int DATA_DEPTH  = 64;
    localparam int N_ARITH     = 24;
    localparam int N_FWD       = 32;
    localparam int N_STORE     = 8;
    localparam int N_LOAD      = 8;  // each load comes with one consumer
    localparam int N_ZERO      = 8;
    localparam int N_MIX       = 24;
    localparam int N_TOTAL     = N_ARITH + N_FWD + N_STORE + 2 * N_LOAD + N_ZERO + N_MIX;
    localparam int CYCLE_LIMIT = 2 * N_TOTAL + 50;

    logic              clk = 1'b0;
    logic              reset;
    logic              instr_valid;
    instr_word_t       instr;
    logic              instr_ready;
    logic              wb_valid;
    logic              wb_we;
    logic [REG_AW-1:0] wb_rd;
    logic [XLEN-1:0]   wb_data;

    integer seed = 32'h62b9_8053;
    int     cycle = 0;
    int     pass_count = 0;
    int     fail_count = 0;

    logic [XLEN-1:0]   m_regs [32];
    logic [XLEN-1:0]   m_mem [DATA_DEPTH];
    logic [11:0]       stored_offs [$];  // addresses already written
    logic              ex_load = 1'b0;   // model of the load sitting in EX
    logic [REG_AW-1:0] ex_load_rd = '0;

    // expected trace, one entry per accepted instruction
    logic              exp_we_q [$];
    logic [REG_AW-1:0] exp_rd_q [$];
    logic [XLEN-1:0]   exp_data_q [$];
    int                exp_cyc_q [$];

    cpu_top #(.DATA_DEPTH(DATA_DEPTH)) dut0 (
        .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
        .instr_ready(instr_ready), .wb_valid(wb_valid), .wb_we(wb_we),
        .wb_rd(wb_rd), .wb_data(wb_data)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    function automatic logic [XLEN-1:0] rnd(input int unsigned n);
        logic [XLEN-1:0] r;
        r = $random(seed);
        return r % n;
    endfunction

    function automatic logic [XLEN-1:0] sext12(input logic [11:0] v);
        return {{(XLEN-12){v[11]}}, v};
    endfunction

    function automatic logic [31:0] enc_3r(input logic [OP3R_W-1:0] op, input logic [4:0] rk,
                                           input logic [4:0] rj, input logic [4:0] rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_ri(input logic [OP2RI_W-1:0] op, input logic [11:0] si12,
                                           input logic [4:0] rj, input logic [4:0] rd);
        return {op, si12, rj, rd};
    endfunction

    function automatic logic [OP3R_W-1:0] pick_3r_op();
        case (rnd(6))
            0:       return OP_ADD_W;
            1:       return OP_SUB_W;
            2:       return OP_AND;
            3:       return OP_OR;
            4:       return OP_XOR;
            default: return OP_SLT;
        endcase
    endfunction

    // source registers per form: 3R rj/rk, addi and ld rj, st rj/rd
    function automatic logic reads_reg(input logic [31:0] w, input logic [4:0] r);
        case (w[31:15])
            OP_ADD_W, OP_SUB_W, OP_AND, OP_OR, OP_XOR, OP_SLT:
                return (w[9:5] == r) || (w[14:10] == r);
            default: ;
        endcase
        case (w[31:22])
            OP_ADDI_W, OP_LD_W: return w[9:5] == r;
            OP_ST_W:            return (w[9:5] == r) || (w[4:0] == r);
            default:            return 1'b0;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] exp);
        if (got !== exp)
        begin
            $display("mismatch %s: got %h expected %h (cycle %0d)", name, got, exp, cycle);
            fail_count++;
        end
        else
            pass_count++;
    endtask

    task automatic model_exec(input logic [31:0] w, input int acc_cycle);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] res;
        int              idx;
        logic            we;
        a    = m_regs[w[9:5]];
        b    = m_regs[w[14:10]];
        addr = a + sext12(w[21:10]);
        idx  = (addr >> 2) % DATA_DEPTH;  // word access, low bits ignored
        we   = (w[4:0] != 5'd0);
        res  = '0;
        case (w[31:15])
            OP_ADD_W: res = a + b;
            OP_SUB_W: res = a - b;
            OP_AND:   res = a & b;
            OP_OR:    res = a | b;
            OP_XOR:   res = a ^ b;
            OP_SLT:   res = ($signed(a) < $signed(b)) ? 1 : 0;
            default:
                case (w[31:22])
                    OP_ADDI_W: res = addr;
                    OP_LD_W:   res = m_mem[idx];
                    OP_ST_W:
                    begin
                        m_mem[idx] = m_regs[w[4:0]];
                        res = addr;
                        we  = 1'b0;
                    end
                    default:   we = 1'b0;
                endcase
        endcase
        if (we)
            m_regs[w[4:0]] = res;
        exp_we_q.push_back(we);
        exp_rd_q.push_back(w[4:0]);
        exp_data_q.push_back(res);
        exp_cyc_q.push_back(acc_cycle);
    endtask

    // outputs are sampled on the falling edge, away from the drive edge
    always @(negedge clk)
    begin
        if (reset)
        begin
            compare_value("instr_ready", XLEN'(instr_ready),
                          XLEN'(!(instr_valid && ex_load && reads_reg(instr, ex_load_rd))));
            if (wb_valid)
            begin
                if (exp_we_q.size() == 0)
                begin
                    $display("error: an instruction retired with none outstanding, cycle %0d",
                             cycle);
                    fail_count++;
                end
                else
                begin
                    compare_value("wb_we", XLEN'(wb_we), XLEN'(exp_we_q[0]));
                    compare_value("wb_rd", XLEN'(wb_rd), XLEN'(exp_rd_q[0]));
                    if (exp_we_q[0])
                        compare_value("wb_data", wb_data, exp_data_q[0]);
                    // the coming edge ends the WB cycle
                    compare_value("trace_cycle", XLEN'(cycle + 1), XLEN'(exp_cyc_q[0] + 3));
                    void'(exp_we_q.pop_front());
                    void'(exp_rd_q.pop_front());
                    void'(exp_data_q.pop_front());
                    void'(exp_cyc_q.pop_front());
                end
            end
            if (instr_valid && instr_ready)
            begin
                model_exec(instr, cycle + 1);  // taken at the coming edge
                ex_load    = (instr[31:22] == OP_LD_W) && (instr[4:0] != 5'd0);
                ex_load_rd = instr[4:0];
            end
            else
                ex_load = 1'b0;
        end
    end

    // presents one instruction and holds it until accepted
    task automatic issue(input logic [31:0] w);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= w;
        @(negedge clk);
        while (!instr_ready)
            @(negedge clk);
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    task automatic drain();
        idle(1);
        while (exp_we_q.size() != 0)
            @(posedge clk);
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("test %s done, %0d errors", name, fail_count - fails_before);
    endtask

    initial
    begin
        int          fails;
        logic [11:0] off;
        logic [4:0]  rx;
        reset       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < 32; i++)
            m_regs[i] = '0;

        fails = fail_count;
        repeat (4)
        begin
            @(negedge clk);
            compare_value("wb_valid", XLEN'(wb_valid), '0);
        end
        @(posedge clk);  // fifth edge under reset
        reset <= 1'b1;
        @(negedge clk);
        compare_value("wb_valid", XLEN'(wb_valid), '0);
        compare_value("instr_ready", XLEN'(instr_ready), 1);
        report_test("1 reset state", fails);

        fails = fail_count;
        for (int i = 0; i < N_ARITH; i++)
        begin
            if (i < 8 || rnd(3) == 0)  // seed values first
                issue(enc_ri(OP_ADDI_W, 12'(rnd(4096)), 5'(5 + rnd(27)), 5'(5 + rnd(27))));
            else
                issue(enc_3r(pick_3r_op(), 5'(5 + rnd(27)), 5'(5 + rnd(27)), 5'(5 + rnd(27))));
            idle(rnd(2));
        end
        drain();
        report_test("2 independent arithmetic", fails);

        fails = fail_count;
        for (int i = 0; i < N_FWD; i++)
        begin
            if (rnd(4) == 0)
                issue(enc_ri(OP_ADDI_W, 12'(rnd(4096)), 5'(1 + rnd(4)), 5'(1 + rnd(4))));
            else
                issue(enc_3r(pick_3r_op(), 5'(1 + rnd(4)), 5'(1 + rnd(4)), 5'(1 + rnd(4))));
        end
        drain();
        report_test("3 forwarding", fails);

        fails = fail_count;
        for (int i = 0; i < N_STORE; i++)
        begin
            off = {4'b0, 6'(rnd(64)), 2'(rnd(4))};
            stored_offs.push_back(off);
            issue(enc_ri(OP_ST_W, off, 5'd0, 5'(5 + rnd(27))));
        end
        for (int i = 0; i < N_LOAD; i++)
        begin
            rx = 5'(1 + rnd(31));
            issue(enc_ri(OP_LD_W, stored_offs[rnd(stored_offs.size())], 5'd0, rx));
            if (i % 2 == 0)
                issue(enc_3r(pick_3r_op(), 5'(rnd(32)), rx, 5'(1 + rnd(31))));
            else
                issue(enc_ri(OP_ST_W, stored_offs[rnd(stored_offs.size())], 5'd0, rx));
        end
        drain();
        report_test("4 load-use stall", fails);

        fails = fail_count;
        issue(enc_3r(OP_ADD_W, 5'd2, 5'd1, 5'd0));
        issue(enc_ri(OP_ADDI_W, 12'h7ff, 5'd3, 5'd0));
        issue(enc_3r(OP_OR, 5'd0, 5'd4, 5'd6));
        issue(enc_3r(OP_ADD_W, 5'd0, 5'd0, 5'd7));
        issue(enc_ri(OP_LD_W, stored_offs[0], 5'd0, 5'd0));  // load into r0 must not stall
        issue(enc_3r(OP_SUB_W, 5'd0, 5'd5, 5'd8));
        issue(enc_ri(OP_ADDI_W, 12'h123, 5'd0, 5'd9));
        issue(enc_3r(OP_XOR, 5'd9, 5'd0, 5'd10));
        drain();
        report_test("5 r0 behavior", fails);

        fails = fail_count;
        for (int i = 0; i < N_MIX; i++)
        begin
            case (rnd(4))
                0: issue(enc_ri(OP_ADDI_W, 12'(rnd(4096)), 5'(rnd(9)), 5'(1 + rnd(8))));
                1: issue(enc_ri(OP_LD_W, stored_offs[rnd(stored_offs.size())], 5'd0,
                                5'(1 + rnd(8))));
                2:
                begin
                    off = {4'b0, 6'(rnd(64)), 2'(rnd(4))};
                    stored_offs.push_back(off);
                    issue(enc_ri(OP_ST_W, off, 5'd0, 5'(rnd(9))));
                end
                default: issue(enc_3r(pick_3r_op(), 5'(rnd(9)), 5'(rnd(9)), 5'(1 + rnd(8))));
            endcase
            idle(rnd(2));
        end
        drain();
        report_test("6 trace timing", fails);

        $display("checks passed %0d, checks failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial
    begin
        wait (cycle >= CYCLE_LIMIT);
        $display("error: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
logic/cpu_pkg.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/hazard_forward.sv
logic/execute_stage.sv
logic/mem_stage.sv
logic/cpu_top.sv
bench/cpu_assert.sv
bench/cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile with verilator, run, and look for the pass line in the log
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module cpu_tb -o cpu_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/cpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
    exit 0
fi
exit 1
